/* verif/rv_core_patterns.txt */
# instr    pc       kind rd value, all hex
# kind 0 expects a write-back of value to rd, kind 1 an illegal strobe
# Immediate ops on ADDI results
7FF00093 00000100 0 01 000007FF
FFF08113 00000104 0 02 000007FE
5550C193 00000108 0 03 000002AA
1001E213 0000010C 0 04 000003AA
0F017293 00000110 0 05 000000F0
7FF12313 00000114 0 06 00000001
FFF0B393 00000118 0 07 00000001
# R-type ops on 0x80000000 and 0xFFFFFFFF
80000437 0000011C 0 08 80000000
FFF00493 00000120 0 09 FFFFFFFF
00940533 00000124 0 0A 7FFFFFFF
40A405B3 00000128 0 0B 00000001
00942633 0000012C 0 0C 00000001
0084B6B3 00000130 0 0D 00000000
40B45733 00000134 0 0E C0000000
00B757B3 00000138 0 0F 60000000
00A49833 0000013C 0 10 80000000
009848B3 00000140 0 11 7FFFFFFF
00146933 00000144 0 12 800007FF
00E4F9B3 00000148 0 13 C0000000
12345A17 0000014C 0 14 1234514C
# x0 write then read, illegal ops on x5, then read x5
00108013 00000150 0 00 00000800
00100AB3 00000154 0 15 000007FF
000002FF 00000158 1 05 00000000
20115293 0000015C 1 05 00000000
00028B13 00000160 0 16 000000F0

/* rv_core.f */
design/rv_pkg.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_regfile.sv
design/rv_core.sv
verif/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module rv_core_tb -Mdir obj_dir -f rv_core.f
out=$(./obj_dir/Vrv_core_tb)
echo "$out"
if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1

/* verif/rv_core_tb.sv */
// Testbench for the RV32I execution core
// Reads instruction patterns, issues them back to back and
// checks write-back and illegal strobes against the patterns
`timescale 1ns/1ns

module rv_core_tb;

    localparam int LATENCY     = 2;   // Issue to strobe, in cycles
    localparam int STROBE_WAIT = 10;
    localparam int DRAIN_WAIT  = 50;

    typedef struct packed {
        rv_pkg::word_t    instr;
        rv_pkg::word_t    pc;
        logic             kind;  // 1 for illegal
        rv_pkg::reg_idx_t rd;
        rv_pkg::word_t    value;
    } pattern_t;

    typedef struct packed {
        int               num;
        int               cycle;  // Cycle of the issue
        logic             kind;
        rv_pkg::reg_idx_t rd;
        rv_pkg::word_t    value;
    } expect_t;

    logic             clk;
    logic             reset;
    logic             issue_valid;
    rv_pkg::word_t    instr;
    rv_pkg::word_t    pc;
    logic             wb_valid;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;
    logic             illegal;

    pattern_t patterns[$];
    expect_t  expected[$];
    int       cycle;
    int       head;  // Next expected entry to check
    int       passed;
    int       failed;

    rv_core DUT (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic load_patterns();
        int               fd;
        int               n;
        logic [8*120-1:0] line;
        logic [31:0]      f_instr, f_pc, f_kind, f_rd, f_value;
        pattern_t         p;
        fd = $fopen("verif/rv_core_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                // Comment and blank lines do not scan as five fields
                if (n > 0 && $sscanf(line, "%h %h %h %h %h",
                        f_instr, f_pc, f_kind, f_rd, f_value) == 5) begin
                    p.instr = f_instr;
                    p.pc    = f_pc;
                    p.kind  = f_kind[0];
                    p.rd    = f_rd[4:0];
                    p.value = f_value;
                    patterns.push_back(p);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_strobe(input expect_t e);
        int errs;
        errs = 0;
        if (cycle != e.cycle + LATENCY) begin
            $display("test %0d: strobe came %0d cycles after issue instead of %0d",
                e.num, cycle - e.cycle, LATENCY);
            errs++;
        end
        if (e.kind) begin
            if (!illegal || wb_valid) begin
                $display("test %0d: expected an illegal strobe but got a write-back", e.num);
                errs++;
            end
        end else if (!wb_valid) begin
            $display("test %0d: expected a write-back but got an illegal strobe", e.num);
            errs++;
        end else begin
            if (wb_rd != e.rd) begin
                $display("** Error test %0d: wb_rd is 0x%h, expected 0x%h", e.num, wb_rd, e.rd);
                errs++;
            end
            if (wb_data != e.value) begin
                $display("** Error test %0d: wb_data is 0x%h, expected 0x%h",
                    e.num, wb_data, e.value);
                errs++;
            end
        end
        if (errs == 0) begin
            passed++;
            $display("test %0d: ok", e.num);
        end else begin
            failed++;
            $display("test %0d: failed", e.num);
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!reset) begin
            if (head < expected.size() && cycle - expected[head].cycle > STROBE_WAIT) begin
                $display("test %0d: no strobe within %0d cycles of its issue",
                    expected[head].num, STROBE_WAIT);
                failed++;
                head++;
            end
            if (wb_valid || illegal) begin
                if (head >= expected.size()) begin
                    $display("Strobe at cycle %0d with no instruction outstanding", cycle);
                    failed++;
                end else begin
                    check_strobe(expected[head]);
                    head++;
                end
            end
        end
    end

    initial begin
        expect_t e;
        int      waited;
        clk         = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        load_patterns();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (patterns[i]) begin
            @(posedge clk);
            #2;
            issue_valid = 1'b1;
            instr       = patterns[i].instr;
            pc          = patterns[i].pc;
            e.num       = i;
            e.cycle     = cycle;
            e.kind      = patterns[i].kind;
            e.rd        = patterns[i].rd;
            e.value     = patterns[i].value;
            expected.push_back(e);
        end
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        waited = 0;
        while (head < expected.size() && waited < DRAIN_WAIT) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);  // Room for stray strobes
        $display("tests %0d, passed %0d, failed %0d", patterns.size(), passed, failed);
        if (failed == 0 && head == expected.size() && patterns.size() > 0) begin
            $display("** PASS **");
        end else begin
            if (head != expected.size()) begin
                $display("Strobes still outstanding after %0d cycles", DRAIN_WAIT);
            end
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* design/rv_core.sv */
// Top level of the two-stage RV32I execution core
// Decode, execute and register file instances
`timescale 1ns/1ns

module rv_core #(
    parameter int NUM_REGS = rv_pkg::DEFAULT_NUM_REGS
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue_valid,
    input  rv_pkg::word_t    instr,
    input  rv_pkg::word_t    pc,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data,
    output logic             illegal
);

    rv_pkg::decoded_op_t dec_op;
    rv_pkg::wb_t         wb;
    rv_pkg::reg_idx_t    rs1;
    rv_pkg::reg_idx_t    rs2;
    rv_pkg::word_t       rs1_data;
    rv_pkg::word_t       rs2_data;

    rv_decode #(.NUM_REGS(NUM_REGS)) u_decode (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .instr       (instr),
        .pc          (pc),
        .dec_op      (dec_op)
    );

    rv_execute u_execute (
        .clk      (clk),
        .reset    (reset),
        .dec_op   (dec_op),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb),
        .illegal  (illegal)
    );

    rv_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
        .clk      (clk),
        .reset    (reset),
        .wb       (wb),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

/* design/rv_regfile.sv */
// Register file of the RV32I execution core
// Write-back commit and two combinational read ports, x0 reads as zero
`timescale 1ns/1ns

module rv_regfile #(
    parameter int NUM_REGS = rv_pkg::DEFAULT_NUM_REGS
) (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::wb_t      wb,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);

    localparam int IDX_W = $clog2(NUM_REGS);

    rv_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd[IDX_W-1:0]] <= wb.data;
        end
    end

    // Out of range indices only occur on ops already flagged illegal
    assign rs1_data = (rs1 == '0 || int'(rs1) >= NUM_REGS) ? '0 : regs[rs1[IDX_W-1:0]];
    assign rs2_data = (rs2 == '0 || int'(rs2) >= NUM_REGS) ? '0 : regs[rs2[IDX_W-1:0]];

    a_wb_in_range: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> int'(wb.rd) < NUM_REGS);

endmodule

/* design/rv_execute.sv */
// Execute stage of the RV32I execution core
// Operand select with forwarding, ALU, write-back and illegal strobes
`timescale 1ns/1ns

module rv_execute (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::decoded_op_t dec_op,
    output rv_pkg::reg_idx_t    rs1,
    output rv_pkg::reg_idx_t    rs2,
    input  rv_pkg::word_t       rs1_data,
    input  rv_pkg::word_t       rs2_data,
    output rv_pkg::wb_t         wb,
    output logic                illegal
);

    rv_pkg::word_t src_a;
    rv_pkg::word_t src_b;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t result;
    logic          fwd_a;
    logic          fwd_b;
    logic [4:0]    shamt;

    assign rs1 = dec_op.rs1;
    assign rs2 = dec_op.rs2;

    // Previous result not yet in the register file
    assign fwd_a = wb.valid && wb.rd != '0 && wb.rd == dec_op.rs1;
    assign fwd_b = wb.valid && wb.rd != '0 && wb.rd == dec_op.rs2;

    assign src_a = fwd_a ? wb.data : rs1_data;
    assign src_b = fwd_b ? wb.data : rs2_data;

    always_comb begin
        if (dec_op.zero_a) begin
            op_a = '0;  // LUI
        end else if (dec_op.use_pc) begin
            op_a = dec_op.pc;  // AUIPC
        end else begin
            op_a = src_a;
        end
    end

    assign op_b  = dec_op.use_imm ? dec_op.imm : src_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_op.alu_op)
            rv_pkg::ALU_ADD:  result = op_a + op_b;
            rv_pkg::ALU_SUB:  result = op_a - op_b;
            rv_pkg::ALU_SLL:  result = op_a << shamt;
            rv_pkg::ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: result = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:  result = op_a ^ op_b;
            rv_pkg::ALU_SRL:  result = op_a >> shamt;
            rv_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   result = op_a | op_b;
            rv_pkg::ALU_AND:  result = op_a & op_b;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb      <= '0;
            illegal <= 1'b0;
        end else begin
            wb.valid <= dec_op.valid;
            wb.rd    <= dec_op.rd;
            wb.data  <= result;
            illegal  <= dec_op.illegal;
        end
    end

    // One strobe kind per decoded op
    a_wb_not_illegal: assert property (@(posedge clk) disable iff (reset)
        !(wb.valid && illegal));

endmodule

/* design/rv_decode.sv */
// Decode stage of the RV32I execution core
// Field extraction, immediates, ALU operation and illegal checks
`timescale 1ns/1ns

module rv_decode #(
    parameter int NUM_REGS = rv_pkg::DEFAULT_NUM_REGS
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_valid,
    input  rv_pkg::word_t       instr,
    input  rv_pkg::word_t       pc,
    output rv_pkg::decoded_op_t dec_op
);

    rv_pkg::opcode_t     opcode;
    rv_pkg::funct3_t     funct3;
    rv_pkg::funct7_t     funct7;
    rv_pkg::reg_idx_t    rd;
    rv_pkg::reg_idx_t    rs1;
    rv_pkg::reg_idx_t    rs2;
    logic                bad_funct7;
    logic                bad_index;
    logic                unknown;
    rv_pkg::decoded_op_t next_op;

    function automatic rv_pkg::alu_op_e alu_sel(input rv_pkg::funct3_t f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            rv_pkg::F3_ADD_SUB: op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:     op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:     op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU:    op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:     op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SR:      op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:      op = rv_pkg::ALU_OR;
            default:            op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    function automatic logic idx_bad(input rv_pkg::reg_idx_t idx);
        return int'(idx) >= NUM_REGS;
    endfunction

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        bad_funct7 = 1'b0;
        if (opcode == rv_pkg::OPC_OP) begin
            bad_funct7 = !(funct7 == rv_pkg::F7_BASE || (funct7 == rv_pkg::F7_ALT &&
                (funct3 == rv_pkg::F3_ADD_SUB || funct3 == rv_pkg::F3_SR)));
        end else if (opcode == rv_pkg::OPC_OP_IMM) begin
            if (funct3 == rv_pkg::F3_SLL) begin
                bad_funct7 = funct7 != rv_pkg::F7_BASE;
            end else if (funct3 == rv_pkg::F3_SR) begin
                bad_funct7 = funct7 != rv_pkg::F7_BASE && funct7 != rv_pkg::F7_ALT;
            end
        end
    end

    always_comb begin
        next_op        = '0;
        next_op.rd     = rd;
        next_op.rs1    = rs1;
        next_op.rs2    = rs2;
        next_op.pc     = pc;
        next_op.imm    = {{20{instr[31]}}, instr[31:20]};  // I-type
        next_op.alu_op = rv_pkg::ALU_ADD;
        bad_index      = idx_bad(rd);
        unknown        = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                next_op.alu_op = alu_sel(funct3, instr[30]);
                bad_index      = idx_bad(rd) || idx_bad(rs1) || idx_bad(rs2);
            end
            rv_pkg::OPC_OP_IMM: begin
                next_op.alu_op  = alu_sel(funct3, funct3 == rv_pkg::F3_SR && instr[30]);
                next_op.use_imm = 1'b1;
                bad_index       = idx_bad(rd) || idx_bad(rs1);
            end
            rv_pkg::OPC_LUI: begin
                next_op.imm     = {instr[31:12], 12'b0};
                next_op.use_imm = 1'b1;
                next_op.zero_a  = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                next_op.imm     = {instr[31:12], 12'b0};
                next_op.use_imm = 1'b1;
                next_op.use_pc  = 1'b1;
            end
            default: unknown = 1'b1;
        endcase
        next_op.illegal = unknown || bad_funct7 || bad_index;
        next_op.valid   = !next_op.illegal;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_op <= '0;
        end else if (issue_valid) begin
            dec_op <= next_op;
        end else begin
            dec_op.valid   <= 1'b0;
            dec_op.illegal <= 1'b0;
        end
    end

    // One registered op per issue, either legal or illegal
    a_one_op_per_issue: assert property (@(posedge clk) disable iff (reset)
        $onehot0({dec_op.valid, dec_op.illegal}) &&
        (dec_op.valid || dec_op.illegal) == $past(issue_valid));

endmodule

/* design/rv_pkg.sv */
// Shared definitions for the RV32I execution core
// Data word and register index types, field types
// ALU operation enum, opcode and funct constants
// Decoded operation and write-back structs
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    parameter int DEFAULT_NUM_REGS = 32;  // Full RV32I set, 16 gives RV32E

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;  // SRL and SRA
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // SUB and SRA

    typedef struct packed {
        logic     valid;
        logic     illegal;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;  // Immediate as operand B
        logic     use_pc;   // PC as operand A
        logic     zero_a;   // Operand A forced to zero
        word_t    imm;
        word_t    pc;
    } decoded_op_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage
